// ==== bench/div_checker.sv ====
/*
 * Divider bus checker
 * Watches the AXI4-Lite channels, models the register map and divider
 * and compares every response
 */
`timescale 1ns/100ps
`default_nettype none

module div_checker (
   input  logic                    s_ps_dma_aclk,
   input  logic                    arst_n_i,
   input  tproc_div_pkg::axil_req_t axil_req_i,
   input  tproc_div_pkg::axil_rsp_t axil_rsp_i,
   output int                      err_cnt_o,
   output int                      chk_cnt_o
);
   import tproc_div_pkg::*;

   data_t                 op1;
   data_t                 op2;
   data_t                 exp_quo;
   data_t                 exp_rem;
   cnt_t                  exp_done;
   logic                  settled;      // No start since STATUS last read idle
   logic [1:0]            exp_bresp;
   addr_t                 rd_addr;
   logic [2*DATA_W-1:0]   exp_pair;
   logic                  wr_pend;      // Write accepted, response not yet taken
   logic                  rd_pend;      // Read accepted, data not yet taken
   axil_req_t             req_prev;
   axil_rsp_t             rsp_prev;

   initial begin
      err_cnt_o = 0;
      chk_cnt_o = 0;
   end

   function automatic logic in_map(addr_t a);
      return (a == REG_CTRL) || (a == REG_EXT_I1) || (a == REG_EXT_I2) ||
             (a == REG_EXT_O1) || (a == REG_EXT_O2) || (a == REG_STATUS);
   endfunction

   // Quotient in the upper word, remainder in the lower
   function automatic logic [2*DATA_W-1:0] ref_div(data_t a, data_t b);
      if (b == '0) return {{DATA_W{1'b1}}, a};
      return {a / b, a % b};
   endfunction

   task automatic compare_word(string name, logic [31:0] exp, logic [31:0] act);
      chk_cnt_o++;
      if (exp !== act) begin
         err_cnt_o++;
         $display("mismatch at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
      end
   endtask

   task automatic note_failure(string what);
      err_cnt_o++;
      $display("Error at %0t ns: %s", $time, what);
   endtask

   task automatic check_read(addr_t addr, data_t data, logic [1:0] resp);
      if (!in_map(addr)) begin
         compare_word("rresp", RESP_SLVERR, resp);
         compare_word("rdata", '0, data);
      end else begin
         compare_word("rresp", RESP_OKAY, resp);
         case (addr)
            REG_CTRL:   compare_word("CTRL", '0, data);
            REG_EXT_I1: compare_word("EXT_I1", op1, data);
            REG_EXT_I2: compare_word("EXT_I2", op2, data);
            REG_EXT_O1: if (settled) compare_word("EXT_O1", exp_quo, data);
            REG_EXT_O2: if (settled) compare_word("EXT_O2", exp_rem, data);
            default: begin
               compare_word("STATUS[30:16]", '0, data[30:16]);
               if (settled) compare_word("STATUS.busy", '0, data[31]);
               if (!data[31]) begin                     // Pipe drained
                  compare_word("STATUS.done_cnt", exp_done, data[15:0]);
                  settled = 1'b1;
               end
            end
         endcase
      end
   endtask

   //////////////////////////////////////////////////
   // Monitor and model
   always @(posedge s_ps_dma_aclk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         op1       = '0;
         op2       = '0;
         exp_quo   = '0;
         exp_rem   = '0;
         exp_done  = '0;
         settled   = 1'b1;
         exp_bresp = RESP_OKAY;
         rd_addr   = '0;
         wr_pend   = 1'b0;
         rd_pend   = 1'b0;
         req_prev  = '0;
         rsp_prev  = '0;
      end else begin
         // Ready and valid flags follow the channel state
         compare_word("awready", !wr_pend, axil_rsp_i.awready);
         compare_word("wready", !wr_pend, axil_rsp_i.wready);
         compare_word("bvalid", wr_pend, axil_rsp_i.bvalid);
         compare_word("arready", !rd_pend, axil_rsp_i.arready);
         compare_word("rvalid", rd_pend, axil_rsp_i.rvalid);

         // Responses held under back-pressure
         if (rsp_prev.bvalid && !req_prev.bready) begin
            if (!axil_rsp_i.bvalid) note_failure("bvalid dropped before bready");
            compare_word("bresp (held)", rsp_prev.bresp, axil_rsp_i.bresp);
         end
         if (rsp_prev.rvalid && !req_prev.rready) begin
            if (!axil_rsp_i.rvalid) note_failure("rvalid dropped before rready");
            compare_word("rdata (held)", rsp_prev.rdata, axil_rsp_i.rdata);
            compare_word("rresp (held)", rsp_prev.rresp, axil_rsp_i.rresp);
         end

         if (axil_rsp_i.bvalid && axil_req_i.bready)
            compare_word("bresp", exp_bresp, axil_rsp_i.bresp);
         if (axil_rsp_i.rvalid && axil_req_i.rready)
            check_read(rd_addr, axil_rsp_i.rdata, axil_rsp_i.rresp);
         if (wr_pend && axil_req_i.bready) wr_pend = 1'b0;
         if (rd_pend && axil_req_i.rready) rd_pend = 1'b0;

         if (axil_req_i.arvalid && axil_rsp_i.arready) begin
            rd_addr = axil_req_i.araddr;
            rd_pend = 1'b1;
         end

         if (axil_req_i.awvalid && axil_req_i.wvalid && axil_rsp_i.awready && axil_rsp_i.wready) begin
            exp_bresp = in_map(axil_req_i.awaddr) ? RESP_OKAY : RESP_SLVERR;
            wr_pend   = 1'b1;
            case (axil_req_i.awaddr)
               REG_EXT_I1: op1 = axil_req_i.wdata;
               REG_EXT_I2: op2 = axil_req_i.wdata;
               REG_CTRL: begin
                  if (axil_req_i.wdata[CTRL_CLR_BIT]) exp_done = '0;
                  if (axil_req_i.wdata[CTRL_START_BIT]) begin
                     exp_pair = ref_div(op1, op2);
                     exp_quo  = exp_pair[2*DATA_W-1:DATA_W];
                     exp_rem  = exp_pair[DATA_W-1:0];
                     exp_done = exp_done + 1'b1;
                     settled  = 1'b0;
                  end
               end
               default: ;   // Read-only or unmapped
            endcase
         end

         req_prev = axil_req_i;
         rsp_prev = axil_rsp_i;
      end
   end

endmodule

`default_nettype wire

// ==== bench/tb_tproc_div.sv ====
/*
 * Divider testbench
 * AXI4-Lite host with random operands and random back-pressure
 */
`timescale 1ns/100ps
`default_nettype none

module tb_tproc_div;
   import tproc_div_pkg::*;

   localparam int N_RAND      = 24;
   localparam int N_BURST     = 8;
   localparam int N_BP        = 7;
   localparam int N_DIV       = N_RAND + N_BURST + 1 + N_BP;
   localparam int TIMEOUT_CYC = N_DIV * 60 + 2000;

   logic      s_ps_dma_aclk;
   logic      arst_n;
   axil_req_t axil_req;
   axil_rsp_t axil_rsp;
   int        err_cnt;
   int        chk_cnt;
   integer    seed;
   int        stall_base;      // Zero gives occasional short stalls

   tproc_div_top i_dut (
      .s_ps_dma_aclk ( s_ps_dma_aclk ),
      .arst_n_i      ( arst_n        ),
      .axil_req_i    ( axil_req      ),
      .axil_rsp_o    ( axil_rsp      )
   );

   div_checker i_checker (
      .s_ps_dma_aclk ( s_ps_dma_aclk ),
      .arst_n_i      ( arst_n        ),
      .axil_req_i    ( axil_req      ),
      .axil_rsp_i    ( axil_rsp      ),
      .err_cnt_o     ( err_cnt       ),
      .chk_cnt_o     ( chk_cnt       )
   );

   initial begin
      s_ps_dma_aclk = 1'b0;
      forever #10 s_ps_dma_aclk = ~s_ps_dma_aclk;
   end

   //////////////////////////////////////////////////
   // Host helpers
   function automatic int pick_stall();
      if (stall_base > 0) return stall_base + ($random(seed) & 3);
      return (($random(seed) & 3) == 0) ? 1 + ($random(seed) & 3) : 0;
   endfunction

   // Every fifth divisor is zero, others span many magnitudes
   function automatic data_t rand_divisor(int idx);
      data_t raw;
      raw = $random(seed);
      if (idx % 5 == 4) return '0;
      return raw >> ($random(seed) & 31);
   endfunction

   task automatic bus_write(input addr_t addr, input data_t data);
      int stall;
      stall = pick_stall();
      @(posedge s_ps_dma_aclk);
      #1;
      axil_req.awaddr  = addr;
      axil_req.awvalid = 1'b1;
      axil_req.wdata   = data;
      axil_req.wstrb   = 4'hF;
      axil_req.wvalid  = 1'b1;
      do begin
         @(posedge s_ps_dma_aclk);
      end while (!(axil_rsp.awready && axil_rsp.wready));
      #1;
      axil_req.awvalid = 1'b0;
      axil_req.wvalid  = 1'b0;
      repeat (stall) begin
         @(posedge s_ps_dma_aclk);
         #1;
      end
      axil_req.bready = 1'b1;
      do begin
         @(posedge s_ps_dma_aclk);
      end while (!axil_rsp.bvalid);
      #1;
      axil_req.bready = 1'b0;
   endtask

   task automatic bus_read(input addr_t addr, output data_t data);
      int stall;
      stall = pick_stall();
      @(posedge s_ps_dma_aclk);
      #1;
      axil_req.araddr  = addr;
      axil_req.arvalid = 1'b1;
      do begin
         @(posedge s_ps_dma_aclk);
      end while (!axil_rsp.arready);
      #1;
      axil_req.arvalid = 1'b0;
      repeat (stall) begin
         @(posedge s_ps_dma_aclk);
         #1;
      end
      axil_req.rready = 1'b1;
      do begin
         @(posedge s_ps_dma_aclk);
      end while (!axil_rsp.rvalid);
      data = axil_rsp.rdata;
      #1;
      axil_req.rready = 1'b0;
   endtask

   // Poll STATUS until busy drops
   task automatic wait_idle();
      data_t st;
      st = 32'h8000_0000;
      while (st[31]) bus_read(REG_STATUS, st);
   endtask

   task automatic run_division(input data_t a, input data_t b);
      data_t rd;
      bus_write(REG_EXT_I1, a);
      bus_write(REG_EXT_I2, b);
      bus_write(REG_CTRL, 32'h1);
      wait_idle();
      bus_read(REG_EXT_O1, rd);
      bus_read(REG_EXT_O2, rd);
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   initial begin
      data_t rd;
      addr_t bad_addr [4];
      seed       = 67;
      stall_base = 0;
      axil_req   = '0;
      arst_n     = 1'b0;
      bad_addr   = '{6'h04, 6'h10, 6'h2C, 6'h3C};
      repeat (10) @(posedge s_ps_dma_aclk);
      #1;
      arst_n = 1'b1;

      bus_read(REG_STATUS, rd);       // Reset values
      bus_read(REG_EXT_O1, rd);
      bus_read(REG_EXT_O2, rd);
      bus_read(REG_CTRL, rd);

      for (int i = 0; i < N_RAND; i++) run_division($random(seed), rand_divisor(i));

      // Back to back starts, several in the pipe at once
      for (int i = 0; i < N_BURST; i++) begin
         bus_write(REG_EXT_I1, $random(seed));
         bus_write(REG_EXT_I2, rand_divisor(i));
         bus_write(REG_CTRL, 32'h1);
      end
      wait_idle();
      bus_read(REG_EXT_O1, rd);
      bus_read(REG_EXT_O2, rd);

      bus_write(REG_CTRL, 32'h2);     // Clear alone
      bus_read(REG_STATUS, rd);
      bus_write(REG_EXT_I1, $random(seed));
      bus_write(REG_EXT_I2, rand_divisor(1));
      bus_write(REG_CTRL, 32'h3);     // Clear and start together
      wait_idle();

      // Unmapped and read-only targets
      foreach (bad_addr[i]) begin
         bus_write(bad_addr[i], $random(seed));
         bus_read(bad_addr[i], rd);
      end
      bus_write(REG_EXT_O1, $random(seed));
      bus_write(REG_STATUS, $random(seed));
      bus_read(REG_EXT_I1, rd);
      bus_read(REG_EXT_I2, rd);
      bus_read(REG_EXT_O1, rd);
      bus_read(REG_EXT_O2, rd);
      bus_read(REG_STATUS, rd);

      // Heavy back-pressure, the last one outlasts the pipeline
      stall_base = 2;
      for (int i = 0; i < N_BP - 1; i++) run_division($random(seed), rand_divisor(i));
      stall_base = 40;
      run_division($random(seed), rand_divisor(2));

      repeat (5) @(posedge s_ps_dma_aclk);
      $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0 && chk_cnt > 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (TIMEOUT_CYC) @(posedge s_ps_dma_aclk);
      $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
      $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/tproc_div_pkg.sv
logic/axil_reg_decode.sv
logic/div_pipe.sv
logic/result_regs.sv
logic/tproc_div_top.sv
bench/div_checker.sv
bench/tb_tproc_div.sv

// ==== logic/axil_reg_decode.sv ====
/*
 * AXI4-Lite slave for the divider register map
 * Holds EXT_I1/EXT_I2, turns CTRL writes into start and clear pulses
 * and returns read data from its own registers and the result block
 */
`timescale 1ns/100ps
`default_nettype none

module axil_reg_decode (
   input  logic                    s_ps_dma_aclk,
   input  logic                    arst_n_i,
   input  tproc_div_pkg::axil_req_t axil_req_i,
   output tproc_div_pkg::axil_rsp_t axil_rsp_o,
   input  tproc_div_pkg::status_t   status_i,
   output tproc_div_pkg::div_cmd_t  cmd_o,
   output logic                    clr_o
);
   import tproc_div_pkg::*;

   wr_state_e  wr_state_q;
   rd_state_e  rd_state_q;
   logic [1:0] bresp_q;
   logic [1:0] rresp_q;
   data_t      rdata_q;
   data_t      ext_i1_q;
   data_t      ext_i2_q;
   logic       start_q;
   logic       clr_q;
   logic       wr_hs;
   logic       rd_hs;
   data_t      rd_data;
   logic       rd_ok;

   function automatic logic is_mapped(addr_t addr);
      case (addr)
         REG_CTRL, REG_EXT_I1, REG_EXT_I2,
         REG_EXT_O1, REG_EXT_O2, REG_STATUS: is_mapped = 1'b1;
         default:                            is_mapped = 1'b0;
      endcase
   endfunction

   // Address and data are taken together only
   assign wr_hs = (wr_state_q == W_IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
   assign rd_hs = (rd_state_q == R_IDLE) && axil_req_i.arvalid;

   //////////////////////////////////////////////////
   // Write channel
   always_ff @(posedge s_ps_dma_aclk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_state_q <= W_IDLE;
         bresp_q    <= RESP_OKAY;
      end else begin
         case (wr_state_q)
            W_IDLE: if (wr_hs) begin
               wr_state_q <= W_RESP;
               bresp_q    <= is_mapped(axil_req_i.awaddr) ? RESP_OKAY : RESP_SLVERR;
            end
            W_RESP: if (axil_req_i.bready) wr_state_q <= W_IDLE;
            default: wr_state_q <= W_IDLE;
         endcase
      end
   end

   // Writable registers; wstrb is ignored, every write is a full word
   always_ff @(posedge s_ps_dma_aclk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ext_i1_q <= '0;
         ext_i2_q <= '0;
         start_q  <= 1'b0;
         clr_q    <= 1'b0;
      end else begin
         start_q <= 1'b0;                 // Pulses last one cycle
         clr_q   <= 1'b0;
         if (wr_hs) begin
            case (axil_req_i.awaddr)
               REG_CTRL: begin
                  start_q <= axil_req_i.wdata[CTRL_START_BIT];
                  clr_q   <= axil_req_i.wdata[CTRL_CLR_BIT];
               end
               REG_EXT_I1: ext_i1_q <= axil_req_i.wdata;
               REG_EXT_I2: ext_i2_q <= axil_req_i.wdata;
               default: ;                 // Read-only or unmapped
            endcase
         end
      end
   end

   //////////////////////////////////////////////////
   // Read channel
   always_comb begin
      rd_data = '0;
      rd_ok   = 1'b1;
      case (axil_req_i.araddr)
         REG_CTRL:   rd_data = '0;        // Pulses only, nothing to read back
         REG_EXT_I1: rd_data = ext_i1_q;
         REG_EXT_I2: rd_data = ext_i2_q;
         REG_EXT_O1: rd_data = status_i.quotient;
         REG_EXT_O2: rd_data = status_i.remainder;
         REG_STATUS: rd_data = {status_i.busy, {(DATA_W-1-CNT_W){1'b0}}, status_i.done_cnt};
         default:    rd_ok   = 1'b0;
      endcase
   end

   always_ff @(posedge s_ps_dma_aclk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_state_q <= R_IDLE;
         rdata_q    <= '0;
         rresp_q    <= RESP_OKAY;
      end else begin
         case (rd_state_q)
            R_IDLE: if (rd_hs) begin
               rd_state_q <= R_DATA;
               rdata_q    <= rd_data;
               rresp_q    <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            end
            R_DATA: if (axil_req_i.rready) rd_state_q <= R_IDLE;
            default: rd_state_q <= R_IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Outputs
   always_comb begin
      axil_rsp_o.awready = (wr_state_q == W_IDLE);
      axil_rsp_o.wready  = (wr_state_q == W_IDLE);
      axil_rsp_o.bresp   = bresp_q;
      axil_rsp_o.bvalid  = (wr_state_q == W_RESP);
      axil_rsp_o.arready = (rd_state_q == R_IDLE);
      axil_rsp_o.rdata   = rdata_q;
      axil_rsp_o.rresp   = rresp_q;
      axil_rsp_o.rvalid  = (rd_state_q == R_DATA);
   end

   // Operands as they stand when the start pulse leaves
   assign cmd_o = '{valid: start_q, dividend: ext_i1_q, divisor: ext_i2_q};
   assign clr_o = clr_q;

   a_bvalid_hold: assert property (@(posedge s_ps_dma_aclk) disable iff (!arst_n_i)
      axil_rsp_o.bvalid && !axil_req_i.bready |=> axil_rsp_o.bvalid && $stable(axil_rsp_o.bresp));
   a_rvalid_hold: assert property (@(posedge s_ps_dma_aclk) disable iff (!arst_n_i)
      axil_rsp_o.rvalid && !axil_req_i.rready |=> axil_rsp_o.rvalid && $stable(axil_rsp_o.rdata));
   a_cmd_single: assert property (@(posedge s_ps_dma_aclk) disable iff (!arst_n_i)
      cmd_o.valid |=> !cmd_o.valid);

endmodule

`default_nettype wire

// ==== logic/div_pipe.sv ====
/*
 * Pipelined restoring divider
 * One quotient bit per stage, a new command may enter every cycle
 */
`timescale 1ns/100ps
`default_nettype none

module div_pipe (
   input  logic                   s_ps_dma_aclk,
   input  logic                   arst_n_i,
   input  tproc_div_pkg::div_cmd_t cmd_i,
   output tproc_div_pkg::div_res_t res_o
);
   import tproc_div_pkg::*;

   // Payload of one stage
   typedef struct packed {
      data_t divisor;
      data_t rem;       // Partial remainder
      data_t quo;       // Dividend bits still to shift in, quotient bits below
   } stage_t;

   logic [DIV_STAGES-1:0] valid_q;
   stage_t                stage_in [DIV_STAGES];
   stage_t                stage_q  [DIV_STAGES];

   // One restoring step: shift in the next dividend bit, subtract if it fits
   function automatic stage_t div_step(stage_t s);
      logic [DATA_W:0] rem_sh;
      logic [DATA_W:0] diff;
      logic            fits;
      stage_t          n;
      rem_sh    = {s.rem, s.quo[DATA_W-1]};
      diff      = rem_sh - {1'b0, s.divisor};
      fits      = (rem_sh >= {1'b0, s.divisor});
      n.divisor = s.divisor;
      n.rem     = fits ? diff[DATA_W-1:0] : rem_sh[DATA_W-1:0];
      n.quo     = {s.quo[DATA_W-2:0], fits};
      return n;
   endfunction

   //////////////////////////////////////////////////
   // Stage inputs
   always_comb begin
      stage_in[0].divisor = cmd_i.divisor;
      stage_in[0].rem     = '0;
      stage_in[0].quo     = cmd_i.dividend;
      for (int i = 1; i < DIV_STAGES; i++) begin
         stage_in[i] = stage_q[i-1];
      end
   end

   // Valid chain
   always_ff @(posedge s_ps_dma_aclk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_q <= '0;
      end else begin
         valid_q <= {valid_q[DIV_STAGES-2:0], cmd_i.valid};
      end
   end

   // Datapath, a zero divisor falls out as all ones and the dividend
   always_ff @(posedge s_ps_dma_aclk) begin
      for (int i = 0; i < DIV_STAGES; i++) begin
         stage_q[i] <= div_step(stage_in[i]);
      end
   end

   assign res_o.valid     = valid_q[DIV_STAGES-1];
   assign res_o.quotient  = stage_q[DIV_STAGES-1].quo;
   assign res_o.remainder = stage_q[DIV_STAGES-1].rem;

   a_latency: assert property (@(posedge s_ps_dma_aclk) disable iff (!arst_n_i)
      res_o.valid == $past(cmd_i.valid, DIV_STAGES));

endmodule

`default_nettype wire

// ==== logic/result_regs.sv ====
/*
 * Divider result block
 * Keeps the last quotient and remainder, counts completions
 * and flags divisions still in the pipeline
 */
`timescale 1ns/100ps
`default_nettype none

module result_regs (
   input  logic                   s_ps_dma_aclk,
   input  logic                   arst_n_i,
   input  tproc_div_pkg::div_res_t res_i,
   input  logic                   cmd_valid_i,
   input  logic                   clr_i,
   output tproc_div_pkg::status_t  status_o
);
   import tproc_div_pkg::*;

   // Up to DIV_STAGES divisions can be in the pipe at once
   logic [$clog2(DIV_STAGES+1)-1:0] infl_q;
   cnt_t                            done_cnt_q;
   data_t                           quo_q;
   data_t                           rem_q;

   //////////////////////////////////////////////////
   // In-flight tracking
   always_ff @(posedge s_ps_dma_aclk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         infl_q <= '0;
      end else begin
         case ({cmd_valid_i, res_i.valid})
            2'b10:   infl_q <= infl_q + 1'b1;
            2'b01:   infl_q <= infl_q - 1'b1;
            default: infl_q <= infl_q;     // None, or one in and one out
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Completion counter, wraps
   always_ff @(posedge s_ps_dma_aclk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         done_cnt_q <= '0;
      end else if (clr_i) begin
         // Clear wins, a completion in the same cycle still counts
         done_cnt_q <= res_i.valid ? cnt_t'(1) : '0;
      end else if (res_i.valid) begin
         done_cnt_q <= done_cnt_q + 1'b1;
      end
   end

   // Last result, host visible
   always_ff @(posedge s_ps_dma_aclk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         quo_q <= '0;
         rem_q <= '0;
      end else if (res_i.valid) begin
         quo_q <= res_i.quotient;
         rem_q <= res_i.remainder;
      end
   end

   always_comb begin
      status_o.busy      = (infl_q != '0);
      status_o.done_cnt  = done_cnt_q;
      status_o.quotient  = quo_q;
      status_o.remainder = rem_q;
   end

   // A result with nothing in flight means the pipe and the counter disagree
   a_no_underflow: assert property (@(posedge s_ps_dma_aclk) disable iff (!arst_n_i)
      res_i.valid && !cmd_valid_i |-> infl_q != '0);

endmodule

`default_nettype wire

// ==== logic/tproc_div_pkg.sv ====
/*
 * Divider control plane definitions
 * Widths, register map, CTRL bits, AXI4-Lite and divider structs
 */
`default_nettype none

package tproc_div_pkg;

   localparam int DATA_W     = 32;
   localparam int ADDR_W     = 6;
   localparam int DIV_STAGES = DATA_W;   // One quotient bit per stage
   localparam int CNT_W      = 16;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [CNT_W-1:0]  cnt_t;

   //////////////////////////////////////////////////
   // Register map
   localparam addr_t REG_CTRL   = 6'h00;
   localparam addr_t REG_EXT_I1 = 6'h1C;
   localparam addr_t REG_EXT_I2 = 6'h20;
   localparam addr_t REG_EXT_O1 = 6'h30;
   localparam addr_t REG_EXT_O2 = 6'h34;
   localparam addr_t REG_STATUS = 6'h38;

   localparam int CTRL_START_BIT = 0;
   localparam int CTRL_CLR_BIT   = 1;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   //////////////////////////////////////////////////
   // Bus and datapath bundles
   typedef struct packed {
      addr_t      awaddr;
      logic       awvalid;
      data_t      wdata;
      logic [3:0] wstrb;
      logic       wvalid;
      logic       bready;
      addr_t      araddr;
      logic       arvalid;
      logic       rready;
   } axil_req_t;

   typedef struct packed {
      logic       awready;
      logic       wready;
      logic [1:0] bresp;
      logic       bvalid;
      logic       arready;
      data_t      rdata;
      logic [1:0] rresp;
      logic       rvalid;
   } axil_rsp_t;

   typedef struct packed {
      logic  valid;
      data_t dividend;
      data_t divisor;
   } div_cmd_t;

   typedef struct packed {
      logic  valid;
      data_t quotient;
      data_t remainder;
   } div_res_t;

   typedef struct packed {
      logic  busy;
      cnt_t  done_cnt;
      data_t quotient;
      data_t remainder;
   } status_t;

   typedef enum logic {R_IDLE, R_DATA} rd_state_e;
   typedef enum logic {W_IDLE, W_RESP} wr_state_e;

endpackage

`default_nettype wire

// ==== logic/tproc_div_top.sv ====
/*
 * Register-controlled divider top
 * AXI4-Lite decode, divider pipeline and result registers
 */
`timescale 1ns/100ps
`default_nettype none

module tproc_div_top (
   input  logic                    s_ps_dma_aclk,
   input  logic                    arst_n_i,
   input  tproc_div_pkg::axil_req_t axil_req_i,
   output tproc_div_pkg::axil_rsp_t axil_rsp_o
);
   import tproc_div_pkg::*;

   div_cmd_t div_cmd;
   div_res_t div_res;
   status_t  status;
   logic     cnt_clr;

   //////////////////////////////////////////////////
   // Decode
   axil_reg_decode i_decode (
      .s_ps_dma_aclk ( s_ps_dma_aclk ),
      .arst_n_i      ( arst_n_i      ),
      .axil_req_i    ( axil_req_i    ),
      .axil_rsp_o    ( axil_rsp_o    ),
      .status_i      ( status        ),
      .cmd_o         ( div_cmd       ),
      .clr_o         ( cnt_clr       )
   );

   //////////////////////////////////////////////////
   // Execute
   div_pipe i_div_pipe (
      .s_ps_dma_aclk ( s_ps_dma_aclk ),
      .arst_n_i      ( arst_n_i      ),
      .cmd_i         ( div_cmd       ),
      .res_o         ( div_res       )
   );

   //////////////////////////////////////////////////
   // Result
   result_regs i_result (
      .s_ps_dma_aclk ( s_ps_dma_aclk ),
      .arst_n_i      ( arst_n_i      ),
      .res_i         ( div_res       ),
      .cmd_valid_i   ( div_cmd.valid ),   // Starts the in-flight count
      .clr_i         ( cnt_clr       ),
      .status_o      ( status        )
   );

endmodule

`default_nettype wire
